//--- logic/vgaPkg.sv
// Fixed 640x480 at 25 MHz VGA mode only; colour table holds the NES palette in RGB565
package vgaPkg;

    // ----------------------------------------------------------------------
    // Horizontal and vertical timing in pixel clocks and lines
    // ----------------------------------------------------------------------
    localparam int hVisible = 640;
    localparam int hFront   = 16;
    localparam int hSync    = 96;
    localparam int hWhole   = 800;              // Includes the 48 pixel back porch

    localparam int vVisible = 480;
    localparam int vFront   = 10;
    localparam int vSync    = 2;
    localparam int vWhole   = 525;

    // PPU lines 241 and 260 doubled onto the VGA raster
    localparam int vblankStartLine = 482;
    localparam int vblankEndLine   = 520;

    typedef logic [9:0]  pixelCount;            // Enough for 800 and 525
    typedef logic [5:0]  colorIndex;            // NES colour number
    typedef logic [15:0] rgb565;                // Packed as blue, green, red from msb

    // NES colour number to RGB565, gaps in the master palette are black
    localparam rgb565 rgbTable [64] = '{
        16'h73ae, 16'h88c4, 16'ha800, 16'h9808, 16'h7011, 16'h1015, 16'h0014, 16'h004f,
        16'h0168, 16'h0220, 16'h0280, 16'h11e0, 16'h59e3, 16'h0000, 16'h0000, 16'h0000,
        16'hbdf7, 16'heb80, 16'he9c4, 16'hf010, 16'hb817, 16'h581c, 16'h015b, 16'h0a79,
        16'h0391, 16'h04a0, 16'h0540, 16'h3c80, 16'h8c00, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hfde7, 16'hfcab, 16'hfc54, 16'hfbde, 16'hb3bf, 16'h63bf, 16'h3cdf,
        16'h3dfe, 16'h1690, 16'h4ee9, 16'h9fcb, 16'hdf40, 16'h0000, 16'h0000, 16'h0000,
        16'hffff, 16'hff35, 16'hfeb8, 16'hfe5a, 16'hfe3f, 16'hde3f, 16'hb5ff, 16'haedf,
        16'ha73f, 16'ha7fc, 16'hbf95, 16'hcff6, 16'hf7f3, 16'h0000, 16'h0000, 16'h0000
    };

endpackage

//--- logic/ppuRegPkg.sv
// CPU register map of the picture processor; background palette only, no sprite or scroll state
package ppuRegPkg;

    // ----------------------------------------------------------------------
    // Register selects as seen on the CPU address lines 2..0
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        regCtrl0,       // NMI enable and address step
        regCtrl1,       // Mask bits, kept but unused here
        regStatus,      // VBlank in bit 7
        regSprAddr,     // Ignored
        regSprData,     // Ignored
        regScroll,      // Ignored
        regAddr,        // Two writes, high byte first
        regData         // VRAM or palette access
    } regSelect;

    typedef logic [13:0] vramAddr;              // 16 KB PPU address space
    typedef logic [3:0]  palIndex;

    // Address map
    localparam vramAddr paletteBase = 14'h3F00;
    localparam vramAddr paletteEnd  = 14'h3F10; // Sprite palette would start here

    // Control 0 bit positions
    localparam int ctrlNmiBit  = 7;
    localparam int ctrlStepBit = 2;             // 0 steps by 1, 1 steps by 32

    // Background palette contents after reset
    localparam vgaPkg::colorIndex palResetTable [16] = '{
        6'h12, 6'h16, 6'h30, 6'h38,
        6'h00, 6'h17, 6'h26, 6'h07,
        6'h00, 6'h16, 6'h00, 6'h30,
        6'h00, 6'h38, 6'h28, 6'h10
    };

endpackage

//--- logic/palBus.sv
// Palette access path; rdData is combinational from index, write stores at the clock edge
interface palBus;

    import ppuRegPkg::*;
    import vgaPkg::*;

    logic      write;       // One cycle strobe
    palIndex   index;
    colorIndex wrData;
    colorIndex rdData;      // Follows index without delay

    modport regSide (
        output write, index, wrData,
        input  rdData
    );

    modport memSide (
        input  write, index, wrData,
        output rdData
    );

endinterface

//--- logic/vgaTiming.sv
// 800x525 raster at 25 MHz only; hs and vs are active high, all outputs decoded from the counters
module vgaTiming (
    input  logic CLK25,
    input  logic arstN,
    output logic hs,
    output logic vs,
    output logic visible,
    output logic vblankStart,
    output logic vblankEnd
);

    import vgaPkg::*;

    pixelCount x;           // Pixel position in the line
    pixelCount y;           // Line number in the frame

    // ----------------------------------------------------------------------
    // Raster counters
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            x <= '0;
            y <= '0;
        end else begin
            if (x == pixelCount'(hWhole - 1)) begin
                x <= '0;
                y <= (y == pixelCount'(vWhole - 1)) ? '0 : y + 1'b1; // Next line or frame
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Sync windows after the front porch
    assign hs = (x >= pixelCount'(hVisible + hFront))
             && (x <  pixelCount'(hVisible + hFront + hSync));    // 656..751
    assign vs = (y >= pixelCount'(vVisible + vFront))
             && (y <  pixelCount'(vVisible + vFront + vSync));    // Lines 490 and 491

    assign visible = (x < pixelCount'(hVisible)) && (y < pixelCount'(vVisible));

    // VBlank line events, one pulse at the start of the line
    assign vblankStart = (x == '0) && (y == pixelCount'(vblankStartLine));
    assign vblankEnd   = (x == '0) && (y == pixelCount'(vblankEndLine));

endmodule

//--- logic/cpuRegs.sv
// CPU strobes are single cycle with no handshake; VRAM read data must return in the same cycle
module cpuRegs (
    input  logic                 CLK25,
    input  logic                 arstN,
    input  ppuRegPkg::regSelect  regSel,
    input  logic                 regWrite,
    input  logic                 regRead,
    input  logic [7:0]           wrData,
    input  logic                 vblankStart,
    input  logic                 vblankEnd,
    input  logic [7:0]           vramRdData,
    output logic [7:0]           rdData,
    output ppuRegPkg::vramAddr   vramRdAddr,
    output logic                 vramWrite,
    output ppuRegPkg::vramAddr   vramWrAddr,
    output logic [7:0]           vramWrData,
    output logic                 nmi,
    palBus.regSide               pal
);

    import ppuRegPkg::*;

    logic [7:0] ctrl0;
    logic [7:0] ctrl1;          // Mask register, no function in this design
    vramAddr    addr;           // Shared CPU address pointer
    logic       firstWrite;     // Toggle for the two byte address write
    logic [7:0] readBuf;        // Delayed VRAM read data
    logic       vblank;
    vramAddr    step;
    logic       inVram;
    logic       inPalette;
    logic       dataWrite;
    logic       statusRead;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    assign inVram     = addr < paletteBase;
    assign inPalette  = (addr >= paletteBase) && (addr < paletteEnd);
    assign step       = ctrl0[ctrlStepBit] ? vramAddr'(32) : vramAddr'(1);
    assign dataWrite  = regWrite && (regSel == regData);
    assign statusRead = regRead && !regWrite && (regSel == regStatus); // Write wins

    assign vramRdAddr = addr;                   // External memory answers combinationally

    // Palette port, entry picked by the low address nibble
    assign pal.index  = addr[3:0];
    assign pal.wrData = wrData[5:0];
    assign pal.write  = dataWrite && inPalette;

    // ----------------------------------------------------------------------
    // Register file
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            ctrl0      <= 8'h00;
            ctrl1      <= 8'h00;
            addr       <= '0;
            firstWrite <= 1'b1;
            readBuf    <= 8'hFF;
            rdData     <= 8'h00;
            vramWrite  <= 1'b0;
        end else begin
            vramWrite <= 1'b0;                  // Pulse only
            if (regWrite) begin
                case (regSel)
                    regCtrl0: ctrl0 <= wrData;
                    regCtrl1: ctrl1 <= wrData;
                    regAddr: begin
                        if (firstWrite)
                            addr[13:8] <= wrData[5:0];  // High byte, top bits dropped
                        else
                            addr[7:0]  <= wrData;
                        firstWrite <= !firstWrite;
                    end
                    regData: begin
                        vramWrite <= inVram;    // Palette writes go through pal
                        addr      <= addr + step;
                    end
                    default: ;                  // Sprite and scroll writes ignored
                endcase
            end else if (regRead) begin
                case (regSel)
                    regStatus: begin
                        rdData     <= {vblank, 7'b000_0000};
                        firstWrite <= 1'b1;
                    end
                    regData: begin
                        if (inVram) begin
                            rdData  <= readBuf; // Previous fetch
                            readBuf <= vramRdData;
                        end else if (inPalette) begin
                            rdData <= {2'b00, pal.rdData};
                        end else begin
                            rdData <= 8'h00;    // Sprite palette not present
                        end
                        addr <= addr + step;
                    end
                    default: rdData <= 8'h00;   // Write only registers
                endcase
            end
        end
    end

    // Write port payload
    always_ff @(posedge CLK25) begin
        if (dataWrite && inVram) begin
            vramWrAddr <= addr;
            vramWrData <= wrData;
        end
    end

    // ----------------------------------------------------------------------
    // VBlank flag and NMI level
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            vblank <= 1'b0;
            nmi    <= 1'b0;
        end else begin
            if (vblankStart) begin
                vblank <= 1'b1;
                nmi    <= ctrl0[ctrlNmiBit];    // Enable sampled at line 482
            end else if (vblankEnd) begin
                vblank <= 1'b0;
                nmi    <= 1'b0;
            end else if (statusRead) begin
                vblank <= 1'b0;                 // Read returns the old value
            end
        end
    end

endmodule

//--- logic/paletteRam.sv
// Background palette only, 16 entries of 6 bits; entry 0 is the backdrop shown on every pixel
module paletteRam (
    input  logic              CLK25,
    input  logic              arstN,
    palBus.memSide            pal,
    output vgaPkg::colorIndex backdropIndex
);

    import ppuRegPkg::*;
    import vgaPkg::*;

    colorIndex palMem [16];

    // Reset loads the power on colours
    always_ff @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                palMem[i] <= palResetTable[i];
            end
        end else if (pal.write) begin
            palMem[pal.index] <= pal.wrData;
        end
    end

    assign pal.rdData    = palMem[pal.index];  // CPU read, no latency
    assign backdropIndex = palMem[0];

endmodule

//--- logic/colorLookup.sv
// Video outputs lag the raster counters by one clock; black outside the 640x480 area
module colorLookup (
    input  logic              CLK25,
    input  logic              arstN,
    input  vgaPkg::colorIndex backdropIndex,
    input  logic              visible,
    output logic [4:0]        red,
    output logic [5:0]        green,
    output logic [4:0]        blue
);

    import vgaPkg::*;

    rgb565 rgb;

    assign rgb = rgbTable[backdropIndex];

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------
    always_ff @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (visible) begin
            red   <= rgb[4:0];                  // Low field drives red
            green <= rgb[10:5];
            blue  <= rgb[15:11];                // High field drives blue
        end else begin
            red   <= '0;                        // Blanking
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

//--- logic/ppuTop.sv
// Background colour path only with no tiles or sprites; VRAM is an external 16 KB memory
module ppuTop (
    input  logic                CLK25,
    input  logic                arstN,
    input  ppuRegPkg::regSelect regSel,
    input  logic                regWrite,
    input  logic                regRead,
    input  logic [7:0]          wrData,
    output logic [7:0]          rdData,
    output ppuRegPkg::vramAddr  vramRdAddr,
    input  logic [7:0]          vramRdData,
    output logic                vramWrite,
    output ppuRegPkg::vramAddr  vramWrAddr,
    output logic [7:0]          vramWrData,
    output logic [4:0]          red,
    output logic [5:0]          green,
    output logic [4:0]          blue,
    output logic                hs,
    output logic                vs,
    output logic                nmi
);

    import vgaPkg::*;

    logic      visible;
    logic      vblankStart;
    logic      vblankEnd;
    colorIndex backdropIndex;

    palBus pal ();                              // Register file to palette

    // ----------------------------------------------------------------------
    // Blocks
    // ----------------------------------------------------------------------
    vgaTiming uTiming (
        .CLK25, .arstN, .hs, .vs, .visible, .vblankStart, .vblankEnd
    );

    cpuRegs uRegs (
        .CLK25, .arstN, .regSel, .regWrite, .regRead, .wrData,
        .vblankStart, .vblankEnd, .vramRdData, .rdData, .vramRdAddr,
        .vramWrite, .vramWrAddr, .vramWrData, .nmi,
        .pal (pal.regSide)
    );

    paletteRam uPalette (
        .CLK25, .arstN, .pal (pal.memSide), .backdropIndex
    );

    colorLookup uColor (
        .CLK25, .arstN, .backdropIndex, .visible, .red, .green, .blue
    );

endmodule

//--- verification/ppuTb.sv
// Assumes the fixed 800x525 raster from reset; VRAM model answers reads in the same cycle
module ppuTb;

    import vgaPkg::*;
    import ppuRegPkg::*;

    typedef enum logic [1:0] {waitNone, waitVblank, waitAfter, waitVisible} waitKind;
    typedef enum logic [1:0] {opNone, opRead, opWrite} opKind;
    typedef enum logic [2:0] {expNone, expRd, expWr, expVram, expPtr, expRgb} expKind;

    typedef struct packed {
        waitKind    waitFor;
        opKind      op;
        regSelect   sel;
        logic [7:0] data;
        expKind     kind;
        logic [7:0] expData;    // Byte, or colour number for expRgb
        vramAddr    addr;       // Write address, pointer or model address
    } stepRow;

    localparam int frameCycles   = hWhole * vWhole;
    localparam int timeoutCycles = 4 * frameCycles;    // Table waits through about three frames
    localparam int stepCount     = 43;

    logic       CLK25, arstN, regWrite, regRead;
    regSelect   regSel;
    logic [7:0] wrData, rdData, vramRdData, vramWrData;
    vramAddr    vramRdAddr, vramWrAddr;
    logic       vramWrite, hs, vs, nmi;
    logic [4:0] red, blue;
    logic [5:0] green;

    logic [7:0] vram [16384];       // External 16 KB memory model
    integer     seed;
    int         tx;                 // Reference raster position
    int         ty;
    int         cycles     = 0;
    int         checks     = 0;
    int         errors     = 0;
    logic [7:0] ctrlShadow = 8'h00; // Last control 0 value taken by the DUT
    logic       nmiArmed   = 1'b0;

    // ----------------------------------------------------------------------
    // Stimulus table: wait, access, expected result
    // ----------------------------------------------------------------------
    stepRow steps [stepCount] = '{
        '{waitVisible, opNone,  regCtrl0,  8'h00, expRgb,  8'h12, 14'h0000}, // Reset backdrop
        '{waitNone,    opWrite, regAddr,   8'h3F, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h04, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regData,   8'hC5, expNone, 8'h00, 14'h0000}, // Top bits dropped
        '{waitNone,    opWrite, regData,   8'h16, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regData,   8'hE7, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regData,   8'h38, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h3F, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h04, expNone, 8'h00, 14'h0000},
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h05, 14'h0000}, // No read buffer
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h16, 14'h0000},
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h27, 14'h0000},
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h38, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h3F, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h10, expNone, 8'h00, 14'h0000},
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h00, 14'h0000}, // Past the palette
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h3F, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h00, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regData,   8'h2A, expNone, 8'h00, 14'h0000}, // New backdrop
        '{waitVisible, opNone,  regCtrl0,  8'h00, expRgb,  8'h2A, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h21, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h00, expNone, 8'h00, 14'h0000},
        '{waitNone,    opRead,  regData,   8'h00, expRd,   8'hFF, 14'h0000}, // Buffer after reset
        '{waitNone,    opRead,  regData,   8'h00, expVram, 8'h00, 14'h2100},
        '{waitNone,    opRead,  regData,   8'h00, expVram, 8'h00, 14'h2101},
        '{waitNone,    opRead,  regData,   8'h00, expVram, 8'h00, 14'h2102},
        '{waitNone,    opWrite, regCtrl0,  8'h04, expNone, 8'h00, 14'h0000}, // Step 32
        '{waitNone,    opWrite, regAddr,   8'h20, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h00, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regData,   8'h5A, expWr,   8'h5A, 14'h2000},
        '{waitNone,    opWrite, regData,   8'hA5, expWr,   8'hA5, 14'h2020},
        '{waitNone,    opWrite, regData,   8'h3C, expWr,   8'h3C, 14'h2040},
        '{waitNone,    opWrite, regCtrl0,  8'h80, expNone, 8'h00, 14'h0000}, // NMI on, step 1
        '{waitVblank,  opRead,  regStatus, 8'h00, expRd,   8'h80, 14'h0000},
        '{waitNone,    opRead,  regStatus, 8'h00, expRd,   8'h00, 14'h0000}, // Cleared by read
        '{waitAfter,   opNone,  regCtrl0,  8'h00, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regCtrl0,  8'h00, expNone, 8'h00, 14'h0000}, // NMI off
        '{waitVblank,  opRead,  regStatus, 8'h00, expRd,   8'h80, 14'h0000},
        '{waitAfter,   opNone,  regCtrl0,  8'h00, expNone, 8'h00, 14'h0000},
        '{waitNone,    opWrite, regAddr,   8'h3F, expNone, 8'h00, 14'h0000}, // High byte
        '{waitNone,    opRead,  regStatus, 8'h00, expRd,   8'h00, 14'h0000}, // Toggle reset
        '{waitNone,    opWrite, regAddr,   8'h3F, expPtr,  8'h00, 14'h3F60}  // Low byte kept
    };

    ppuTop UUT (.*);

    initial begin
        CLK25 = 1'b0;
        forever #50 CLK25 = ~CLK25;
    end

    // VRAM model, random fill over the whole address space
    initial begin
        seed = 32'h7b53_cb2a;
        for (int i = 0; i < 16384; i++) begin
            vram[i] = 8'($random(seed));
        end
    end

    assign vramRdData = vram[vramRdAddr];

    always @(posedge CLK25) begin
        if (vramWrite) begin
            vram[vramWrAddr] <= vramWrData;     // Record DUT writes
        end
    end

    // Reference raster position, same value as the DUT counters
    always @(posedge CLK25 or negedge arstN) begin
        if (!arstN) begin
            tx <= 0;
            ty <= 0;
        end else if (tx == hWhole - 1) begin
            tx <= 0;
            ty <= (ty == vWhole - 1) ? 0 : ty + 1;
        end else begin
            tx <= tx + 1;
        end
    end

    always @(posedge CLK25) begin
        cycles++;
        if (cycles > timeoutCycles) begin
            $display("Timeout after %0d cycles, stimulus table did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Compare tasks and the local colour entries
    // ----------------------------------------------------------------------
    task automatic checkByte(string name, logic [7:0] got, logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkAddr(string name, vramAddr got, vramAddr exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkRgb(string name, rgb565 got, rgb565 exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic rgb565 tableRgb(colorIndex idx);
        case (idx)
            6'h12:   return 16'he9c4;           // Reset backdrop
            6'h2A:   return 16'h4ee9;
            default: return 16'h0000;
        endcase
    endfunction

    // Sync windows, blanking and NMI level on every falling edge
    always @(negedge CLK25) begin
        if (tx == 0 && ty == vblankStartLine) begin
            nmiArmed = ctrlShadow[ctrlNmiBit]; // Enable as seen at line 482
        end
        checkBit("hs", hs, tx >= 656 && tx < 752);
        checkBit("vs", vs, ty >= 490 && ty < 492);
        checkBit("nmi", nmi, nmiArmed
                 && (ty * hWhole + tx > vblankStartLine * hWhole)
                 && (ty * hWhole + tx <= vblankEndLine * hWhole));
        if (hs || vs) begin
            checkRgb("rgb", {blue, green, red}, 16'h0000);
        end
    end

    // ----------------------------------------------------------------------
    // One table row: wait, strobe for one cycle, check on the next falling edge
    // ----------------------------------------------------------------------
    task automatic applyStep(stepRow s);
        case (s.waitFor)
            waitVblank:  do @(negedge CLK25); while (ty != vblankStartLine + 1);
            waitAfter:   do @(negedge CLK25); while (ty != vblankEndLine + 1);
            waitVisible: do @(negedge CLK25); while (!(ty == 240 && tx == 320));
            default: ;
        endcase
        regSel   = s.sel;
        regWrite = (s.op == opWrite);
        regRead  = (s.op == opRead);
        wrData   = s.data;
        @(posedge CLK25);
        if (s.op == opWrite && s.sel == regCtrl0) begin
            ctrlShadow = s.data;
        end
        @(negedge CLK25);
        regWrite = 1'b0;
        regRead  = 1'b0;
        checkBit("vramWrite", vramWrite, s.kind == expWr);
        case (s.kind)
            expRd:   checkByte("rdData", rdData, s.expData);
            expVram: checkByte("rdData", rdData, vram[s.addr]); // Byte at previous address
            expWr: begin
                checkAddr("vramWrAddr", vramWrAddr, s.addr);
                checkByte("vramWrData", vramWrData, s.expData);
            end
            expPtr:  checkAddr("vramRdAddr", vramRdAddr, s.addr);
            expRgb:  checkRgb("rgb", {blue, green, red}, tableRgb(s.expData[5:0]));
            default: ;
        endcase
    endtask

    initial begin
        arstN    = 1'b0;
        regSel   = regCtrl0;
        regWrite = 1'b0;
        regRead  = 1'b0;
        wrData   = 8'h00;
        repeat (3) @(negedge CLK25);
        arstN = 1'b1;
        foreach (steps[i]) begin
            applyStep(steps[i]);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- ppu.f
logic/vgaPkg.sv
logic/ppuRegPkg.sv
logic/palBus.sv
logic/vgaTiming.sv
logic/cpuRegs.sv
logic/paletteRam.sv
logic/colorLookup.sv
logic/ppuTop.sv
verification/ppuTb.sv

//--- Bender.yml
package:
  name: ppu

sources:
  # Packages and interface before the blocks that use them
  - logic/vgaPkg.sv
  - logic/ppuRegPkg.sv
  - logic/palBus.sv
  - logic/vgaTiming.sv
  - logic/cpuRegs.sv
  - logic/paletteRam.sv
  - logic/colorLookup.sv
  - logic/ppuTop.sv
  - target: test
    files:
      - verification/ppuTb.sv
